/* logic/scandbl_pkg.sv */
`default_nettype none

package scandbl_pkg;

   // line geometry, identical on the vdp and vga side.
   localparam int LINE_TOTAL    = 96;                        // ticks per line.
   localparam int SYNC_TICKS    = 8;                         // sync pulse length.
   localparam int ACTIVE_PIXELS = LINE_TOTAL - SYNC_TICKS;   // stored pixels.
   localparam int COL_W         = 7;                         // column address bits.

   typedef logic [3:0]  color_t;   // palette index, 0 is transparent.
   typedef logic [11:0] rgb_t;     // red, green, blue nibbles.

   // TMS9918 colours at 4 bits per channel.
   localparam rgb_t PALETTE [16] = '{
      12'h000,   // transparent.
      12'h000,   // black.
      12'h2c4,   // medium green.
      12'h5e7,   // light green.
      12'h55e,   // dark blue.
      12'h77f,   // light blue.
      12'hd54,   // dark red.
      12'h4ef,   // cyan.
      12'hf55,   // medium red.
      12'hf77,   // light red.
      12'hdc5,   // dark yellow.
      12'hec8,   // light yellow.
      12'h2b3,   // dark green.
      12'hc5b,   // magenta.
      12'hccc,   // gray.
      12'hfff    // white.
   };

   typedef enum logic {
      CAP_SYNC,
      CAP_ACTIVE
   } capture_state_t;

   typedef enum logic [1:0] {
      REP_IDLE,
      REP_SYNC,
      REP_ACTIVE
   } replay_state_t;

endpackage

`default_nettype wire

/* logic/clk_enable_gen.sv */
`default_nettype none

module clk_enable_gen (
   input  logic clk,
   input  logic rst_i,
   output logic vga_clk_en_o,
   output logic vdp_clk_en_o
);

   logic [1:0] phase;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         phase        <= 2'd0;
         vga_clk_en_o <= 1'b0;
         vdp_clk_en_o <= 1'b0;
      end else begin
         phase        <= phase + 2'd1;
         vga_clk_en_o <= phase[0];          // every other clock.
         vdp_clk_en_o <= (phase == 2'd3);   // one in four, on a vga tick.
      end
   end

endmodule

`default_nettype wire

/* logic/vdp_line_capture.sv */
`default_nettype none

module vdp_line_capture (
   input  logic                          clk,
   input  logic                          rst_i,
   input  logic                          clk_en_i,
   input  logic                          hsync_i,
   input  scandbl_pkg::color_t           color_i,
   output logic                          wr_en_o,
   output logic                          wr_bank_o,
   output logic [scandbl_pkg::COL_W-1:0] wr_col_o,
   output scandbl_pkg::color_t           wr_color_o,
   output logic                          line_done_o
);

   scandbl_pkg::capture_state_t   state;
   logic                          sync_q;
   logic [scandbl_pkg::COL_W-1:0] col;
   logic                          sync_rise;
   logic                          sync_fall;
   logic                          col_open;

   assign sync_rise = hsync_i & ~sync_q;
   assign sync_fall = ~hsync_i & sync_q;
   assign col_open  = (col < scandbl_pkg::COL_W'(scandbl_pkg::ACTIVE_PIXELS));

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state       <= scandbl_pkg::CAP_SYNC;
         sync_q      <= 1'b1;   // reset counts as sync, first rise ends a real line.
         col         <= '0;
         wr_bank_o   <= 1'b0;
         wr_en_o     <= 1'b0;
         line_done_o <= 1'b0;
      end else begin
         wr_en_o     <= 1'b0;
         line_done_o <= 1'b0;
         if (clk_en_i) begin
            sync_q <= hsync_i;
            if (sync_rise) begin
               line_done_o <= 1'b1;         // line in the old bank is complete.
               wr_bank_o   <= ~wr_bank_o;
               state       <= scandbl_pkg::CAP_SYNC;
            end else if (sync_fall) begin
               state   <= scandbl_pkg::CAP_ACTIVE;
               col     <= scandbl_pkg::COL_W'(1);
               wr_en_o <= 1'b1;             // first pixel comes with the edge.
            end else if (state == scandbl_pkg::CAP_ACTIVE && col_open) begin
               col     <= col + 1'b1;
               wr_en_o <= 1'b1;
            end
         end
      end
   end

   // write address and data follow the sample.
   always_ff @(posedge clk) begin
      if (clk_en_i) begin
         wr_col_o   <= sync_fall ? '0 : col;
         wr_color_o <= color_i;
      end
   end

endmodule

`default_nettype wire

/* logic/line_buffer.sv */
`default_nettype none

module line_buffer (
   input  logic                          clk,
   input  logic                          wr_en_i,
   input  logic                          wr_bank_i,
   input  logic [scandbl_pkg::COL_W-1:0] wr_col_i,
   input  scandbl_pkg::color_t           wr_color_i,
   input  logic                          rd_bank_i,
   input  logic [scandbl_pkg::COL_W-1:0] rd_col_i,
   output scandbl_pkg::color_t           rd_color_o
);

   // bank, then column.
   scandbl_pkg::color_t mem [2][scandbl_pkg::ACTIVE_PIXELS];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_bank_i][wr_col_i] <= wr_color_i;
      end
   end

   always_ff @(posedge clk) begin
      rd_color_o <= mem[rd_bank_i][rd_col_i];   // one clock after the address.
   end

endmodule

`default_nettype wire

/* logic/vga_line_replay.sv */
`default_nettype none

module vga_line_replay (
   input  logic                          clk,
   input  logic                          rst_i,
   input  logic                          clk_en_i,
   input  logic                          line_done_i,
   input  logic                          wr_bank_i,
   output logic                          rd_bank_o,
   output logic [scandbl_pkg::COL_W-1:0] rd_col_o,
   output logic                          hsync_o,
   output logic                          blank_o
);

   scandbl_pkg::replay_state_t    state;
   logic [scandbl_pkg::COL_W-1:0] tick;
   logic                          second;
   logic                          sync_q;
   logic                          blank_q;
   logic [1:0]                    sync_d;
   logic                          blank_d;
   logic                          sync_end;
   logic                          line_end;

   assign sync_end = (tick == scandbl_pkg::COL_W'(scandbl_pkg::SYNC_TICKS - 1));
   assign line_end = (tick == scandbl_pkg::COL_W'(scandbl_pkg::LINE_TOTAL - 1));

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state     <= scandbl_pkg::REP_IDLE;
         tick      <= '0;
         second    <= 1'b0;
         sync_q    <= 1'b0;
         blank_q   <= 1'b1;
         rd_bank_o <= 1'b0;
      end else if (line_done_i) begin
         state     <= scandbl_pkg::REP_SYNC;    // restarts even mid-replay.
         tick      <= '0;
         second    <= 1'b0;
         sync_q    <= 1'b1;
         blank_q   <= 1'b1;
         rd_bank_o <= ~wr_bank_i;               // capture has already moved on.
      end else if (clk_en_i) begin
         case (state)
            scandbl_pkg::REP_SYNC: begin
               tick <= tick + 1'b1;
               if (sync_end) begin
                  state   <= scandbl_pkg::REP_ACTIVE;
                  sync_q  <= 1'b0;
                  blank_q <= 1'b0;
               end
            end
            scandbl_pkg::REP_ACTIVE: begin
               if (line_end) begin
                  tick    <= '0;
                  second  <= 1'b1;
                  blank_q <= 1'b1;
                  if (second) begin
                     state <= scandbl_pkg::REP_IDLE;
                  end else begin
                     state  <= scandbl_pkg::REP_SYNC;   // same line once more.
                     sync_q <= 1'b1;
                  end
               end else begin
                  tick <= tick + 1'b1;
               end
            end
            default: begin
               sync_q  <= 1'b0;
               blank_q <= 1'b1;
            end
         endcase
      end
   end

   // column runs in step with the active ticks.
   always_ff @(posedge clk) begin
      if (clk_en_i) begin
         if (state == scandbl_pkg::REP_SYNC) begin
            rd_col_o <= '0;
         end else if (state == scandbl_pkg::REP_ACTIVE) begin
            rd_col_o <= rd_col_o + 1'b1;
         end
      end
   end

   // store read plus palette register make two clocks.
   always_ff @(posedge clk) begin
      if (rst_i) begin
         sync_d  <= 2'b00;
         blank_d <= 1'b1;
      end else begin
         sync_d  <= {sync_d[0], sync_q};
         blank_d <= blank_q;   // second stage is the palette register.
      end
   end

   assign hsync_o = sync_d[1];
   assign blank_o = blank_d;

endmodule

`default_nettype wire

/* logic/tms9918_palette.sv */
`default_nettype none

module tms9918_palette (
   input  logic                clk,
   input  logic                rst_i,
   input  logic                blank_i,
   input  scandbl_pkg::color_t index_i,
   output scandbl_pkg::rgb_t   rgb_o
);

   scandbl_pkg::rgb_t lookup;

   assign lookup = scandbl_pkg::PALETTE[index_i];

   always_ff @(posedge clk) begin
      if (rst_i || blank_i) begin
         rgb_o <= '0;       // black outside the active part.
      end else begin
         rgb_o <= lookup;
      end
   end

endmodule

`default_nettype wire

/* logic/scandoubler_top.sv */
`default_nettype none

module scandoubler_top (
   input  logic                clk,
   input  logic                rst_i,
   input  logic                vdp_hsync_i,
   input  scandbl_pkg::color_t vdp_color_i,
   output logic                vdp_clk_en_o,
   output logic                vga_clk_en_o,
   output logic                vga_hsync_o,
   output scandbl_pkg::rgb_t   rgb_o
);

   logic                          wr_en;
   logic                          wr_bank;
   logic [scandbl_pkg::COL_W-1:0] wr_col;
   scandbl_pkg::color_t           wr_color;
   logic                          line_done;
   logic                          rd_bank;
   logic [scandbl_pkg::COL_W-1:0] rd_col;
   scandbl_pkg::color_t           rd_color;
   logic                          blank;

   clk_enable_gen enables (
      .clk          (clk),
      .rst_i        (rst_i),
      .vga_clk_en_o (vga_clk_en_o),
      .vdp_clk_en_o (vdp_clk_en_o)
   );

   vdp_line_capture capture (
      .clk         (clk),
      .rst_i       (rst_i),
      .clk_en_i    (vdp_clk_en_o),
      .hsync_i     (vdp_hsync_i),
      .color_i     (vdp_color_i),
      .wr_en_o     (wr_en),
      .wr_bank_o   (wr_bank),
      .wr_col_o    (wr_col),
      .wr_color_o  (wr_color),
      .line_done_o (line_done)
   );

   line_buffer store (
      .clk        (clk),
      .wr_en_i    (wr_en),
      .wr_bank_i  (wr_bank),
      .wr_col_i   (wr_col),
      .wr_color_i (wr_color),
      .rd_bank_i  (rd_bank),
      .rd_col_i   (rd_col),
      .rd_color_o (rd_color)
   );

   vga_line_replay replay (
      .clk         (clk),
      .rst_i       (rst_i),
      .clk_en_i    (vga_clk_en_o),
      .line_done_i (line_done),
      .wr_bank_i   (wr_bank),
      .rd_bank_o   (rd_bank),
      .rd_col_o    (rd_col),
      .hsync_o     (vga_hsync_o),
      .blank_o     (blank)
   );

   tms9918_palette palette (
      .clk     (clk),
      .rst_i   (rst_i),
      .blank_i (blank),
      .index_i (rd_color),
      .rgb_o   (rgb_o)
   );

endmodule

`default_nettype wire

/* bench/scandoubler_tb.sv */
`default_nettype none

module scandoubler_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_LINES     = 42;
   localparam int WAIT_CLOCKS   = (NUM_LINES + 3) * 4 * scandbl_pkg::LINE_TOTAL;
   localparam int ENABLE_WINDOW = 400;

   logic                clk;
   logic                rst_i;
   logic                vdp_hsync_i;
   scandbl_pkg::color_t vdp_color_i;
   logic                vdp_clk_en_o;
   logic                vga_clk_en_o;
   logic                vga_hsync_o;
   scandbl_pkg::rgb_t   rgb_o;

   logic [31:0]         lcg_state = 32'd16528;
   scandbl_pkg::color_t line_store [NUM_LINES][scandbl_pkg::ACTIVE_PIXELS];
   bit                  seen_index [16];
   int                  lines_queued = 0;
   bit                  rise_driven = 1'b0;
   bit                  timed_out = 1'b0;
   int                  value_errors = 0;
   int                  timeout_errors = 0;
   int                  other_errors = 0;
   int                  black_shown [2] = '{0, 0};

   // output monitor state.
   logic                prev_hsync = 1'b0;
   bit                  seen_rise = 1'b0;
   bit                  collecting = 1'b0;
   int                  ticks_since_rise = 0;
   int                  sync_len = 0;
   int                  pix_idx = 0;
   int                  out_lines = 0;

   scandoubler_top u_dut (
      .clk          (clk),
      .rst_i        (rst_i),
      .vdp_hsync_i  (vdp_hsync_i),
      .vdp_color_i  (vdp_color_i),
      .vdp_clk_en_o (vdp_clk_en_o),
      .vga_clk_en_o (vga_clk_en_o),
      .vga_hsync_o  (vga_hsync_o),
      .rgb_o        (rgb_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic scandbl_pkg::color_t random_color();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[19:16];   // low bits of an lcg repeat too soon.
   endfunction

   task automatic check_rgb(input scandbl_pkg::rgb_t got, input scandbl_pkg::rgb_t exp,
                            input string what);
      if (got !== exp) begin
         value_errors++;
         $display("FAIL %0t: %s: got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         value_errors++;
         $display("FAIL %0t: %s: got %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      timeout_errors++;
      timed_out = 1'b1;
      $display("timeout at %0t while waiting for %s", $time, what);
   endtask

   task automatic wait_vdp_tick();
      int n;
      bit found;
      n     = 0;
      found = 1'b0;
      if (timed_out) return;
      while (!found && n < 8) begin
         @(posedge clk);
         #5;
         n++;
         found = vdp_clk_en_o;
      end
      if (!found) report_timeout("vdp_clk_en_o");
   endtask

   task automatic drive_tick(input logic hsync, input scandbl_pkg::color_t color);
      wait_vdp_tick();
      vdp_hsync_i = hsync;
      vdp_color_i = color;
   endtask

   task automatic drive_line(input int line);
      scandbl_pkg::color_t c;
      int                  t;
      for (t = 0; t < scandbl_pkg::LINE_TOTAL; t++) begin
         if (t < scandbl_pkg::SYNC_TICKS) begin
            drive_tick(1'b1, '0);
         end else begin
            c = random_color();
            line_store[line][t - scandbl_pkg::SYNC_TICKS] = c;
            seen_index[c] = 1'b1;
            drive_tick(1'b0, c);
         end
      end
      lines_queued = line + 1;   // shown after the next sync rise.
   endtask

   task automatic check_pixel();
      scandbl_pkg::color_t idx;
      scandbl_pkg::rgb_t   exp;
      idx = line_store[out_lines / 2][pix_idx];
      exp = scandbl_pkg::PALETTE[idx];
      check_rgb(rgb_o, exp, $sformatf("line %0d pixel %0d", out_lines, pix_idx));
      if (idx <= 4'd1) begin
         check_rgb(rgb_o, '0, "transparent or black index");
         black_shown[idx[0]]++;
      end
      pix_idx++;
      if (pix_idx == scandbl_pkg::ACTIVE_PIXELS) begin
         collecting = 1'b0;
         out_lines++;
      end
   endtask

   task automatic sample_vga_tick();
      ticks_since_rise++;
      if (vga_hsync_o && !prev_hsync) begin
         if (seen_rise) begin
            check_count(ticks_since_rise, scandbl_pkg::LINE_TOTAL, "output line length");
         end
         seen_rise        = 1'b1;
         ticks_since_rise = 0;
         sync_len         = 0;
      end
      if (vga_hsync_o) begin
         sync_len++;
         check_rgb(rgb_o, '0, "rgb during sync");
      end
      if (!vga_hsync_o && prev_hsync) begin
         check_count(sync_len, scandbl_pkg::SYNC_TICKS, "output sync length");
         collecting = 1'b1;
         pix_idx    = 0;
         if (out_lines / 2 >= lines_queued) begin
            other_errors++;
            collecting = 1'b0;
            $display("output line %0d appeared with no captured input line", out_lines);
         end
      end
      if (collecting) check_pixel();
      prev_hsync = vga_hsync_o;
   endtask

   task automatic sample_outputs();
      if (!rise_driven) begin
         check_count(int'(vga_hsync_o !== 1'b0), 0, "hsync not low before first line");
         check_rgb(rgb_o, '0, "rgb before first line");
      end
      if (rst_i) begin
         check_count(int'(vga_clk_en_o !== 1'b0), 0, "vga enable not low in reset");
         check_count(int'(vdp_clk_en_o !== 1'b0), 0, "vdp enable not low in reset");
      end
      if (vga_clk_en_o) sample_vga_tick();
   endtask

   initial begin
      forever begin
         @(posedge clk);
         #5;
         sample_outputs();
      end
   end

   initial begin
      int vga_count;
      int vdp_count;
      int stray;
      int n;
      int i;
      vga_count   = 0;
      vdp_count   = 0;
      stray       = 0;
      rst_i       = 1'b1;
      vdp_hsync_i = 1'b1;   // held high so reset looks like a sync.
      vdp_color_i = '0;
      repeat (16) @(posedge clk);
      #5;
      rst_i = 1'b0;

      for (i = 0; i < ENABLE_WINDOW; i++) begin
         @(posedge clk);
         #5;
         if (vga_clk_en_o) vga_count++;
         if (vdp_clk_en_o) begin
            vdp_count++;
            if (!vga_clk_en_o) stray++;
         end
      end
      check_count(vga_count, ENABLE_WINDOW / 2, "vga ticks in window");
      check_count(vdp_count, ENABLE_WINDOW / 4, "vdp ticks in window");
      check_count(stray, 0, "vdp ticks off a vga tick");

      for (i = 0; i < NUM_LINES; i++) begin
         if (i == 1) rise_driven = 1'b1;
         drive_line(i);
      end
      for (i = 0; i < scandbl_pkg::SYNC_TICKS; i++) begin
         drive_tick(1'b1, '0);   // closing sync that stays high.
      end

      n = 0;
      while (!timed_out && out_lines < 2 * NUM_LINES && n < WAIT_CLOCKS) begin
         @(posedge clk);
         #5;
         n++;
      end
      if (!timed_out && out_lines < 2 * NUM_LINES) report_timeout("replayed output lines");

      repeat (2) @(posedge clk);
      for (i = 0; i < 400; i++) begin
         @(posedge clk);
         #5;
         check_count(int'(vga_hsync_o !== 1'b0), 0, "hsync not low in idle");
         check_rgb(rgb_o, '0, "rgb in idle");
      end

      check_count(out_lines, 2 * NUM_LINES, "output line count");
      n = 0;
      for (i = 0; i < 16; i++) begin
         if (seen_index[i]) n++;
      end
      check_count(n, 16, "distinct input indices");
      check_count(int'(black_shown[0] > 0), 1, "pixels with index 0 shown");
      check_count(int'(black_shown[1] > 0), 1, "pixels with index 1 shown");

      $display("errors: %0d value, %0d timeout, %0d other",
               value_errors, timeout_errors, other_errors);
      if (value_errors + timeout_errors + other_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* scandoubler.f */
logic/scandbl_pkg.sv
logic/clk_enable_gen.sv
logic/vdp_line_capture.sv
logic/line_buffer.sv
logic/vga_line_replay.sv
logic/tms9918_palette.sv
logic/scandoubler_top.sv
bench/scandoubler_tb.sv
